//--- Makefile
# Verilator flow for the daq3 control slice testbench
# run from the project root, the testbench reads daq3_cases.txt from here

VERILATOR   ?= verilator
TOP         ?= tb_daq3
FILELIST    ?= project.f
OBJ_DIR     ?= obj_dir
VFLAGS      ?= --timing --assert
BUILD_FLAGS ?= --binary -j 0
SIM_ARGS    ?=

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(BUILD_FLAGS) $(VFLAGS) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)

# the exit status of the simulation is the pass or fail result
sim: build
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(OBJ_DIR)

//--- daq3_cases.txt
# op addr value expect, all hex. W: expect is pslverr. R: expect is read data.
# PIN: value is {clkd[1:0],irq,fdb,fda,trig,bd[10:0]}, expect is the read of addr.
# SPI: addr is slave, +10 no wait for the end, +20 wait states expected; expect is reply byte
R   14 00000000 00000000
R   00 00000000 00000000
R   04 00000000 00000000
W   00 0000a5c3 00000000
R   00 00000000 0000a5c3
W   04 00000005 00000000
R   04 00000000 00000005
W   04 00000002 00000000
R   04 00000000 00000002
PIN 08 000002a5 000002a5
PIN 08 0001355a 0026055a
R   0c 00000000 00000000
PIN 0c 00000800 00000001
PIN 0c 00004000 00000003
W   0c 00000001 00000000
R   0c 00000000 00000002
PIN 0c 00004800 00000003
W   0c 00000003 00000000
PIN 08 00004800 00090000
R   0c 00000000 00000000
PIN 0c 00000000 00000000
SPI 00 0000123a 00000000
SPI 01 00004455 00000000
SPI 02 00000f81 00000000
SPI 02 00801400 000000a7
SPI 00 00800300 0000003c
SPI 11 00007e5a 00000000
SPI 21 000012c3 00000000
R   14 00000000 0000003c
W   20 12345678 00000001
R   20 00000000 00000000
R   00 00000000 0000a5c3
W   18 00000001 00000001
R   1c 00000000 00000000

//--- daq3_gpio.sv
/* status pins are asynchronous and seen SYNC_STAGES+1 cycles after they change
   events catch rising edges on trig and dac_irq only */

`timescale 1ns/1ps
`default_nettype none

module daq3_gpio (
  input  wire                          sys_clk_i,
  input  wire                          rst_n_i,
  input  wire  [daq3_pkg::BD_IN_W-1:0] gpio_bd_i,
  input  wire                          trig_i,
  input  wire                          adc_fda_i,
  input  wire                          adc_fdb_i,
  input  wire                          dac_irq_i,
  input  wire  [1:0]                   clkd_status_i,
  gpio_stat_if.src                     stat
);

  logic [daq3_pkg::STATUS_W-1:0]                         pins_raw;
  logic [daq3_pkg::SYNC_STAGES-1:0][daq3_pkg::STATUS_W-1:0] sync_q;
  logic [daq3_pkg::STATUS_W-1:0]                         sync_last;
  logic [daq3_pkg::STATUS_W-1:0]                         status_q;
  logic [daq3_pkg::EV_W-1:0]                             rise;
  logic [daq3_pkg::EV_W-1:0]                             flags_q;

  // pins placed in register layout, gap bits stay 0
  always_comb begin
    pins_raw = '0;
    pins_raw[daq3_pkg::BD_IN_W-1:0]   = gpio_bd_i;
    pins_raw[daq3_pkg::ST_TRIG]       = trig_i;
    pins_raw[daq3_pkg::ST_ADC_FDA]    = adc_fda_i;
    pins_raw[daq3_pkg::ST_ADC_FDB]    = adc_fdb_i;
    pins_raw[daq3_pkg::ST_DAC_IRQ]    = dac_irq_i;
    pins_raw[daq3_pkg::ST_CLKD_LSB +: 2] = clkd_status_i;
  end

  assign sync_last = sync_q[daq3_pkg::SYNC_STAGES-1];

  // edge against the last registered status
  always_comb begin
    rise = '0;
    rise[daq3_pkg::EV_TRIG] = sync_last[daq3_pkg::ST_TRIG] &
                              ~status_q[daq3_pkg::ST_TRIG];
    rise[daq3_pkg::EV_DAC_IRQ] = sync_last[daq3_pkg::ST_DAC_IRQ] &
                                 ~status_q[daq3_pkg::ST_DAC_IRQ];
  end

  always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_q   <= '0;
      status_q <= '0;
      flags_q  <= '0;
    end else begin
      sync_q   <= {sync_q[daq3_pkg::SYNC_STAGES-2:0], pins_raw};
      status_q <= sync_last;
      // a new edge wins over a clear in the same cycle
      flags_q  <= (flags_q & ~stat.event_clr) | rise;
    end
  end

  assign stat.status      = status_q;
  assign stat.event_flags = flags_q;

endmodule

`default_nettype wire

//--- daq3_ifs.sv
/* internal links between the register block, the SPI engine and the GPIO block
   start and event_clr are single-cycle pulses */

`timescale 1ns/1ps
`default_nettype none

// command path from the register block to the SPI engine
interface spi_cmd_if;

  logic                             start;
  logic [daq3_pkg::SLAVE_W-1:0]     slave;
  daq3_pkg::spi_frame_u             frame;
  logic                             busy;
  logic [daq3_pkg::SPI_RDATA_W-1:0] rdata;

  modport ctrl (
    output start, slave, frame,
    input  busy, rdata
  );

  modport engine (
    input  start, slave, frame,
    output busy, rdata
  );

endinterface

// synchronized pins and sticky events
interface gpio_stat_if;

  logic [daq3_pkg::STATUS_W-1:0] status;
  logic [daq3_pkg::EV_W-1:0]     event_flags;
  logic [daq3_pkg::EV_W-1:0]     event_clr;

  modport src  (output status, event_flags, input  event_clr);
  modport sink (input  status, event_flags, output event_clr);

endinterface

`default_nettype wire

//--- daq3_pkg.sv
/* register map, widths and SPI timing of the daq3 control slice
   all sizes are fixed by the board and are not meant to be overridden */

`default_nettype none

package daq3_pkg;

  // ****************************************
  // bus and pin widths
  // ****************************************

  localparam int ADDR_W      = 8;
  localparam int DATA_W      = 32;
  localparam int BD_IN_W     = 11;
  localparam int BD_OUT_W    = 16;
  localparam int SPI_FRAME_W = 24;
  localparam int STATUS_W    = 22;
  localparam int CTRL_W      = 3;
  localparam int EV_W        = 2;
  localparam int SLAVE_W     = 2;
  localparam int SPI_RDATA_W = 8;

  // register map, byte addresses
  localparam logic [ADDR_W-1:0] REG_BD_OUT   = 8'h00;
  localparam logic [ADDR_W-1:0] REG_CTRL     = 8'h04;
  localparam logic [ADDR_W-1:0] REG_STATUS   = 8'h08;
  localparam logic [ADDR_W-1:0] REG_EVENT    = 8'h0C;
  localparam logic [ADDR_W-1:0] REG_SPI_CMD  = 8'h10;
  localparam logic [ADDR_W-1:0] REG_SPI_STAT = 8'h14;

  // field positions
  localparam int CTRL_SYSREF   = 0;
  localparam int CTRL_ADC_PD   = 1;
  localparam int CTRL_DAC_TXEN = 2;
  localparam int ST_TRIG       = 16;
  localparam int ST_ADC_FDA    = 17;
  localparam int ST_ADC_FDB    = 18;
  localparam int ST_DAC_IRQ    = 19;
  localparam int ST_CLKD_LSB   = 20;
  localparam int EV_TRIG       = 0;
  localparam int EV_DAC_IRQ    = 1;
  localparam int SPI_SLAVE_LSB = 24;
  localparam int SPI_BUSY_BIT  = 31;

  // slave numbers in REG_SPI_CMD
  localparam logic [SLAVE_W-1:0] SLV_CLK = 2'd0;
  localparam logic [SLAVE_W-1:0] SLV_DAC = 2'd1;
  localparam logic [SLAVE_W-1:0] SLV_ADC = 2'd2;

  // ****************************************
  // timing
  // ****************************************

  localparam int SYNC_STAGES = 2;
  localparam int SPI_HALF    = 2;
  localparam int SPI_DIV_W   = $clog2(SPI_HALF);
  localparam int SPI_CNT_W   = $clog2(SPI_FRAME_W + 1);

  localparam logic [SPI_DIV_W-1:0] SPI_DIV_LAST = SPI_DIV_W'(SPI_HALF - 1);
  localparam logic [SPI_CNT_W-1:0] SPI_TURN_BIT = SPI_CNT_W'(16);
  localparam logic [SPI_CNT_W-1:0] SPI_LAST_BIT = SPI_CNT_W'(SPI_FRAME_W - 1);

  // engine states
  localparam logic [1:0] SPI_ST_IDLE  = 2'd0;
  localparam logic [1:0] SPI_ST_SETUP = 2'd1;
  localparam logic [1:0] SPI_ST_SHIFT = 2'd2;
  localparam logic [1:0] SPI_ST_END   = 2'd3;

  // one SPI frame, shifted raw or decoded as rw/addr/data
  typedef struct packed {
    logic        rw;
    logic [14:0] addr;
    logic [7:0]  data;
  } spi_frame_s;

  typedef union packed {
    logic [SPI_FRAME_W-1:0] raw;
    spi_frame_s             f;
  } spi_frame_u;

endpackage

`default_nettype wire

//--- daq3_properties.sv
/* APB and SPI protocol assertions, bound into daq3_top
   start and busy are taken from the internal spi_cmd_if instance */

`timescale 1ns/1ps
`default_nettype none

module daq3_properties (
  input wire                         sys_clk_i,
  input wire                         rst_n_i,
  input wire [daq3_pkg::ADDR_W-1:0]  paddr_i,
  input wire                         psel_i,
  input wire                         penable_i,
  input wire                         pwrite_i,
  input wire                         pready_o,
  input wire                         spi_csn_clk_o,
  input wire                         spi_csn_dac_o,
  input wire                         spi_csn_adc_o,
  input wire                         sdio_oe_o,
  input wire                         start_i,
  input wire                         busy_i
);

  logic cs_idle;
  int   wait_cnt;

  assign cs_idle = spi_csn_clk_o & spi_csn_dac_o & spi_csn_adc_o;

  // length of the current run of wait states
  always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wait_cnt <= 0;
    end else if (!pready_o) begin
      wait_cnt <= wait_cnt + 1;
    end else begin
      wait_cnt <= 0;
    end
  end

  // at most one device selected
  cs_single: assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
    !((!spi_csn_clk_o && !spi_csn_dac_o) || (!spi_csn_clk_o && !spi_csn_adc_o) ||
      (!spi_csn_dac_o && !spi_csn_adc_o)))
    else $error("more than one SPI chip select is low");

  oe_rise_idle: assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
    $rose(sdio_oe_o) |-> cs_idle)
    else $error("sdio_oe_o rose while a chip select was low");

  start_free: assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
    start_i |-> !busy_i)
    else $error("SPI start given while the engine was busy");

  // a wait state belongs to a command write and lasts at most one transfer
  ready_rule: assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
    !pready_o |-> (psel_i && penable_i && pwrite_i &&
                   (paddr_i == daq3_pkg::REG_SPI_CMD) && busy_i &&
                   (wait_cnt < (2 * daq3_pkg::SPI_FRAME_W + 2) * daq3_pkg::SPI_HALF)))
    else $error("pready low outside a busy SPI command write or longer than one transfer");

endmodule

bind daq3_top daq3_properties u_daq3_properties (
  .sys_clk_i     (sys_clk_i),
  .rst_n_i       (rst_n_i),
  .paddr_i       (paddr_i),
  .psel_i        (psel_i),
  .penable_i     (penable_i),
  .pwrite_i      (pwrite_i),
  .pready_o      (pready_o),
  .spi_csn_clk_o (spi_csn_clk_o),
  .spi_csn_dac_o (spi_csn_dac_o),
  .spi_csn_adc_o (spi_csn_adc_o),
  .sdio_oe_o     (sdio_oe_o),
  .start_i       (u_spi_cmd_if.start),
  .busy_i        (u_spi_cmd_if.busy)
);

`default_nettype wire

//--- daq3_regs.sv
/* APB slave, zero wait states except a SPI command write while the engine is busy
   unmapped accesses return 0 with pslverr, unmapped writes are dropped */

`timescale 1ns/1ps
`default_nettype none

module daq3_regs (
  input  wire                              sys_clk_i,
  input  wire                              rst_n_i,

  // apb
  input  wire  [daq3_pkg::ADDR_W-1:0]      paddr_i,
  input  wire                              psel_i,
  input  wire                              penable_i,
  input  wire                              pwrite_i,
  input  wire  [daq3_pkg::DATA_W-1:0]      pwdata_i,
  output logic [daq3_pkg::DATA_W-1:0]      prdata_o,
  output logic                             pready_o,
  output logic                             pslverr_o,

  spi_cmd_if.ctrl                          spi,
  gpio_stat_if.sink                        gpio,

  // board and converter controls
  output logic [daq3_pkg::BD_OUT_W-1:0]    gpio_bd_o,
  output logic                             sysref_o,
  output logic                             adc_pd_o,
  output logic                             dac_txen_o
);

  logic                            access;
  logic                            sel_bd;
  logic                            sel_ctrl;
  logic                            sel_status;
  logic                            sel_event;
  logic                            sel_cmd;
  logic                            sel_stat;
  logic                            mapped;
  logic                            wr_en;
  logic [daq3_pkg::BD_OUT_W-1:0]   bd_out_q;
  logic [daq3_pkg::CTRL_W-1:0]     ctrl_q;
  logic                            start_q;
  logic [daq3_pkg::SLAVE_W-1:0]    slave_q;
  daq3_pkg::spi_frame_u            frame_q;

  // ****************************************
  // address decode
  // ****************************************

  always_comb begin
    access     = psel_i & penable_i;
    sel_bd     = (paddr_i == daq3_pkg::REG_BD_OUT);
    sel_ctrl   = (paddr_i == daq3_pkg::REG_CTRL);
    sel_status = (paddr_i == daq3_pkg::REG_STATUS);
    sel_event  = (paddr_i == daq3_pkg::REG_EVENT);
    sel_cmd    = (paddr_i == daq3_pkg::REG_SPI_CMD);
    sel_stat   = (paddr_i == daq3_pkg::REG_SPI_STAT);
    mapped     = sel_bd | sel_ctrl | sel_status | sel_event | sel_cmd | sel_stat;
    // hold off a new command until the engine is free
    pready_o   = ~(access & pwrite_i & sel_cmd & spi.busy);
    pslverr_o  = access & ~mapped;
    wr_en      = access & pwrite_i & pready_o & mapped;
  end

  // write-1-to-clear, one cycle wide
  assign gpio.event_clr = (wr_en & sel_event) ? pwdata_i[daq3_pkg::EV_W-1:0] : '0;

  // read mux
  always_comb begin
    prdata_o = '0;
    if (access & ~pwrite_i) begin
      if (sel_bd) begin
        prdata_o[daq3_pkg::BD_OUT_W-1:0] = bd_out_q;
      end
      if (sel_ctrl) begin
        prdata_o[daq3_pkg::CTRL_W-1:0] = ctrl_q;
      end
      if (sel_status) begin
        prdata_o[daq3_pkg::STATUS_W-1:0] = gpio.status;
      end
      if (sel_event) begin
        prdata_o[daq3_pkg::EV_W-1:0] = gpio.event_flags;
      end
      if (sel_stat) begin
        prdata_o[daq3_pkg::SPI_BUSY_BIT] = spi.busy;
        prdata_o[daq3_pkg::SPI_RDATA_W-1:0] = spi.rdata;
      end
    end
  end

  // ****************************************
  // registers
  // ****************************************

  always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      bd_out_q <= '0;
      ctrl_q   <= '0;
      start_q  <= 1'b0;
    end else begin
      start_q <= wr_en & sel_cmd;
      if (wr_en & sel_bd) begin
        bd_out_q <= pwdata_i[daq3_pkg::BD_OUT_W-1:0];
      end
      if (wr_en & sel_ctrl) begin
        ctrl_q <= pwdata_i[daq3_pkg::CTRL_W-1:0];
      end
    end
  end

  // command payload, captured with the write
  always_ff @(posedge sys_clk_i) begin
    if (wr_en & sel_cmd) begin
      frame_q.raw <= pwdata_i[daq3_pkg::SPI_FRAME_W-1:0];
      slave_q     <= pwdata_i[daq3_pkg::SPI_SLAVE_LSB +: daq3_pkg::SLAVE_W];
    end
  end

  assign spi.start  = start_q;
  assign spi.slave  = slave_q;
  assign spi.frame  = frame_q;

  assign gpio_bd_o  = bd_out_q;
  assign sysref_o   = ctrl_q[daq3_pkg::CTRL_SYSREF];
  assign adc_pd_o   = ctrl_q[daq3_pkg::CTRL_ADC_PD];
  assign dac_txen_o = ctrl_q[daq3_pkg::CTRL_DAC_TXEN];

endmodule

`default_nettype wire

//--- daq3_spi.sv
/* three-wire SPI master, SCLK idles low, data out on falling edge, MSB first
   slave number 3 selects no device, the frame still runs */

`timescale 1ns/1ps
`default_nettype none

module daq3_spi (
  input  wire   sys_clk_i,
  input  wire   rst_n_i,

  spi_cmd_if.engine spi,

  output logic  spi_csn_clk_o,
  output logic  spi_csn_dac_o,
  output logic  spi_csn_adc_o,
  output logic  spi_clk_o,
  output logic  sdio_o,
  output logic  sdio_oe_o,
  input  wire   sdio_i,
  output logic  spi_dir_o
);

  logic [1:0]                         state_q;
  logic [daq3_pkg::SPI_DIV_W-1:0]     div_q;
  logic [daq3_pkg::SPI_CNT_W-1:0]     bit_q;
  logic                               tick;
  logic [2:0]                         sel_d;
  logic [2:0]                         sel_q;
  logic [2:0]                         csn_q;
  logic                               sclk_q;
  logic                               oe_q;
  logic                               busy_q;
  logic                               rd_q;
  logic [daq3_pkg::SPI_RDATA_W-1:0]   rx_q;
  daq3_pkg::spi_frame_u               shift_q;

  assign tick = (div_q == daq3_pkg::SPI_DIV_LAST);

  // slave number to active-low select, order adc/dac/clk
  always_comb begin
    case (spi.slave)
      daq3_pkg::SLV_CLK: sel_d = 3'b110;
      daq3_pkg::SLV_DAC: sel_d = 3'b101;
      daq3_pkg::SLV_ADC: sel_d = 3'b011;
      default:           sel_d = 3'b111;
    endcase
  end

  // ****************************************
  // control FSM
  // ****************************************

  always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= daq3_pkg::SPI_ST_IDLE;
      div_q   <= '0;
      bit_q   <= '0;
      csn_q   <= 3'b111;
      sclk_q  <= 1'b0;
      oe_q    <= 1'b0;
      busy_q  <= 1'b0;
      rx_q    <= '0;
    end else begin
      case (state_q)
        daq3_pkg::SPI_ST_IDLE: begin
          div_q <= '0;
          // line driven before any select drops
          if (spi.start) begin
            busy_q  <= 1'b1;
            oe_q    <= 1'b1;
            state_q <= daq3_pkg::SPI_ST_SETUP;
          end
        end
        daq3_pkg::SPI_ST_SETUP: begin
          div_q <= div_q + 1'b1;
          if (tick) begin
            div_q   <= '0;
            bit_q   <= '0;
            csn_q   <= sel_q;
            state_q <= daq3_pkg::SPI_ST_SHIFT;
          end
        end
        daq3_pkg::SPI_ST_SHIFT: begin
          div_q <= div_q + 1'b1;
          if (tick) begin
            div_q  <= '0;
            sclk_q <= ~sclk_q;
            if (sclk_q) begin
              // falling edge closes one bit
              bit_q <= bit_q + 1'b1;
              if (rd_q && (bit_q == daq3_pkg::SPI_TURN_BIT - 1'b1)) begin
                oe_q <= 1'b0;
              end
              if (bit_q == daq3_pkg::SPI_LAST_BIT) begin
                state_q <= daq3_pkg::SPI_ST_END;
              end
            end else if (rd_q && (bit_q >= daq3_pkg::SPI_TURN_BIT)) begin
              rx_q <= {rx_q[daq3_pkg::SPI_RDATA_W-2:0], sdio_i};
            end
          end
        end
        daq3_pkg::SPI_ST_END: begin
          csn_q   <= 3'b111;
          oe_q    <= 1'b0;
          busy_q  <= 1'b0;
          state_q <= daq3_pkg::SPI_ST_IDLE;
        end
        default: begin
          state_q <= daq3_pkg::SPI_ST_IDLE;
        end
      endcase
    end
  end

  // shift register and per-frame settings
  always_ff @(posedge sys_clk_i) begin
    if ((state_q == daq3_pkg::SPI_ST_IDLE) && spi.start) begin
      shift_q <= spi.frame;
      rd_q    <= spi.frame.f.rw;
      sel_q   <= sel_d;
    end else if ((state_q == daq3_pkg::SPI_ST_SHIFT) && tick && sclk_q) begin
      shift_q.raw <= {shift_q.raw[daq3_pkg::SPI_FRAME_W-2:0], 1'b0};
    end
  end

  assign spi.busy      = busy_q;
  assign spi.rdata     = rx_q;

  assign spi_csn_clk_o = csn_q[0];
  assign spi_csn_dac_o = csn_q[1];
  assign spi_csn_adc_o = csn_q[2];
  assign spi_clk_o     = sclk_q;
  assign sdio_o        = shift_q.raw[daq3_pkg::SPI_FRAME_W-1];
  assign sdio_oe_o     = oe_q;
  // level shifter direction follows the pad enable
  assign spi_dir_o     = oe_q;

endmodule

`default_nettype wire

//--- daq3_top.sv
/* daq3 control slice, APB register access plus SPI and GPIO to the board
   SPI data pad split into in, out and enable, the pad itself lives outside */

`timescale 1ns/1ps
`default_nettype none

module daq3_top (
  input  wire                              sys_clk_i,
  input  wire                              rst_n_i,

  // apb
  input  wire  [daq3_pkg::ADDR_W-1:0]      paddr_i,
  input  wire                              psel_i,
  input  wire                              penable_i,
  input  wire                              pwrite_i,
  input  wire  [daq3_pkg::DATA_W-1:0]      pwdata_i,
  output logic [daq3_pkg::DATA_W-1:0]      prdata_o,
  output logic                             pready_o,
  output logic                             pslverr_o,

  // board gpio
  input  wire  [daq3_pkg::BD_IN_W-1:0]     gpio_bd_i,
  output logic [daq3_pkg::BD_OUT_W-1:0]    gpio_bd_o,

  // converter status and control
  input  wire                              trig_i,
  input  wire                              adc_fda_i,
  input  wire                              adc_fdb_i,
  input  wire                              dac_irq_i,
  input  wire  [1:0]                       clkd_status_i,
  output logic                             adc_pd_o,
  output logic                             dac_txen_o,
  output logic                             sysref_o,

  // spi
  output logic                             spi_csn_clk_o,
  output logic                             spi_csn_dac_o,
  output logic                             spi_csn_adc_o,
  output logic                             spi_clk_o,
  output logic                             sdio_o,
  output logic                             sdio_oe_o,
  input  wire                              sdio_i,
  output logic                             spi_dir_o
);

  spi_cmd_if   u_spi_cmd_if ();
  gpio_stat_if u_gpio_stat_if ();

  daq3_regs u_regs (
    .sys_clk_i  (sys_clk_i),
    .rst_n_i    (rst_n_i),
    .paddr_i    (paddr_i),
    .psel_i     (psel_i),
    .penable_i  (penable_i),
    .pwrite_i   (pwrite_i),
    .pwdata_i   (pwdata_i),
    .prdata_o   (prdata_o),
    .pready_o   (pready_o),
    .pslverr_o  (pslverr_o),
    .spi        (u_spi_cmd_if.ctrl),
    .gpio       (u_gpio_stat_if.sink),
    .gpio_bd_o  (gpio_bd_o),
    .sysref_o   (sysref_o),
    .adc_pd_o   (adc_pd_o),
    .dac_txen_o (dac_txen_o)
  );

  daq3_spi u_spi (
    .sys_clk_i     (sys_clk_i),
    .rst_n_i       (rst_n_i),
    .spi           (u_spi_cmd_if.engine),
    .spi_csn_clk_o (spi_csn_clk_o),
    .spi_csn_dac_o (spi_csn_dac_o),
    .spi_csn_adc_o (spi_csn_adc_o),
    .spi_clk_o     (spi_clk_o),
    .sdio_o        (sdio_o),
    .sdio_oe_o     (sdio_oe_o),
    .sdio_i        (sdio_i),
    .spi_dir_o     (spi_dir_o)
  );

  daq3_gpio u_gpio (
    .sys_clk_i     (sys_clk_i),
    .rst_n_i       (rst_n_i),
    .gpio_bd_i     (gpio_bd_i),
    .trig_i        (trig_i),
    .adc_fda_i     (adc_fda_i),
    .adc_fdb_i     (adc_fdb_i),
    .dac_irq_i     (dac_irq_i),
    .clkd_status_i (clkd_status_i),
    .stat          (u_gpio_stat_if.src)
  );

endmodule

`default_nettype wire

//--- project.f
daq3_pkg.sv
daq3_ifs.sv
daq3_gpio.sv
daq3_spi.sv
daq3_regs.sv
daq3_top.sv
daq3_properties.sv
tb_daq3.sv

//--- tb_daq3.sv
/* reads daq3_cases.txt relative to the working directory, run from the project root
   stops at the first mismatch */

`timescale 1ns/1ps
`default_nettype none

module tb_daq3;

  localparam int MAX_CASES = 64;

  logic        clk = 1'b0;
  logic        rst_n;
  logic [7:0]  paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic [10:0] gpio_bd_in;
  logic [15:0] gpio_bd;
  logic        trig;
  logic        adc_fda;
  logic        adc_fdb;
  logic        dac_irq;
  logic [1:0]  clkd_status;
  logic        adc_pd;
  logic        dac_txen;
  logic        sysref;
  logic        spi_csn_clk;
  logic        spi_csn_dac;
  logic        spi_csn_adc;
  logic        spi_clk;
  logic        sdio_out;
  logic        sdio_oe;
  logic        sdio_in = 1'b0;
  logic        spi_dir;

  // case table
  string       case_op   [MAX_CASES];
  logic [7:0]  case_addr [MAX_CASES];
  logic [31:0] case_val  [MAX_CASES];
  logic [31:0] case_exp  [MAX_CASES];
  int          num_cases = 0;

  // {slave, frame, reply} per command, in issue order
  logic [33:0] pending_q [$];
  int          frames_sent = 0;
  int          frames_done = 0;

  daq3_top u_daq3_top (
    .sys_clk_i     (clk),
    .rst_n_i       (rst_n),
    .paddr_i       (paddr),
    .psel_i        (psel),
    .penable_i     (penable),
    .pwrite_i      (pwrite),
    .pwdata_i      (pwdata),
    .prdata_o      (prdata),
    .pready_o      (pready),
    .pslverr_o     (pslverr),
    .gpio_bd_i     (gpio_bd_in),
    .gpio_bd_o     (gpio_bd),
    .trig_i        (trig),
    .adc_fda_i     (adc_fda),
    .adc_fdb_i     (adc_fdb),
    .dac_irq_i     (dac_irq),
    .clkd_status_i (clkd_status),
    .adc_pd_o      (adc_pd),
    .dac_txen_o    (dac_txen),
    .sysref_o      (sysref),
    .spi_csn_clk_o (spi_csn_clk),
    .spi_csn_dac_o (spi_csn_dac),
    .spi_csn_adc_o (spi_csn_adc),
    .spi_clk_o     (spi_clk),
    .sdio_o        (sdio_out),
    .sdio_oe_o     (sdio_oe),
    .sdio_i        (sdio_in),
    .spi_dir_o     (spi_dir)
  );

  initial begin
    forever #20 clk = ~clk;
  end

  task automatic report_error(input string msg);
    $display("Fail at %0t ns: %s", $time, msg);
    $display(">>> FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  function automatic logic is_mapped(input logic [7:0] a);
    return a inside {daq3_pkg::REG_BD_OUT, daq3_pkg::REG_CTRL, daq3_pkg::REG_STATUS,
                     daq3_pkg::REG_EVENT, daq3_pkg::REG_SPI_CMD, daq3_pkg::REG_SPI_STAT};
  endfunction

  task automatic load_cases();
    int          fd;
    int          n;
    string       line;
    string       op;
    logic [31:0] a;
    logic [31:0] v;
    logic [31:0] e;
    fd = $fopen("daq3_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open daq3_cases.txt in the working directory");
      $display(">>> FAIL");
      $fatal(1, "no stimulus file");
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n > 0 && line[0] != "#" && num_cases < MAX_CASES) begin
          n = $sscanf(line, "%s %h %h %h", op, a, v, e);
          if (n == 4) begin
            case_op[num_cases]   = op;
            case_addr[num_cases] = a[7:0];
            case_val[num_cases]  = v;
            case_exp[num_cases]  = e;
            num_cases++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // ****************************************
  // APB master
  // ****************************************

  task automatic bus_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err, output int waits);
    @(posedge clk);
    #2;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #2;
    penable = 1'b1;
    waits   = 0;
    @(negedge clk);
    while (!pready) begin
      waits++;
      @(negedge clk);
    end
    if (wr && addr == daq3_pkg::REG_SPI_CMD) begin
      // the previous frame must be over on the pins
      assert (frames_done == frames_sent - 1)
        else report_error("SPI command accepted before the previous frame ended");
    end else begin
      assert (waits == 0)
        else report_error($sformatf("%0d wait states on access to %02h", waits, addr));
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic set_pins(input logic [16:0] p);
    @(posedge clk);
    #2;
    gpio_bd_in  = p[10:0];
    trig        = p[11];
    adc_fda     = p[12];
    adc_fdb     = p[13];
    dac_irq     = p[14];
    clkd_status = p[16:15];
  endtask

  task automatic run_spi(input logic [7:0] flags, input logic [23:0] frame,
                         input logic [7:0] reply);
    logic [31:0] rd;
    logic        err;
    int          waits;
    pending_q.push_back({flags[1:0], frame, reply});
    frames_sent++;
    bus_access(1'b1, daq3_pkg::REG_SPI_CMD, {6'd0, flags[1:0], frame}, rd, err, waits);
    assert (!err) else report_error("pslverr on a SPI command write");
    if (flags[5]) begin
      assert (waits > 0) else report_error("second SPI command saw no wait states");
    end else begin
      assert (waits == 0) else report_error("SPI command held off with the engine idle");
    end
    if (!flags[4]) begin
      // poll busy in REG_SPI_STAT
      do begin
        bus_access(1'b0, daq3_pkg::REG_SPI_STAT, 32'd0, rd, err, waits);
      end while (rd[31]);
      assert (frames_done == frames_sent)
        else report_error($sformatf("%0d of %0d frames seen", frames_done, frames_sent));
      if (frame[23]) begin
        assert (rd[7:0] == reply)
          else report_error($sformatf("read byte %02h, expected %02h", rd[7:0], reply));
      end
    end
  endtask

  // ****************************************
  // SPI slave model
  // ****************************************

  logic        cs_prev   = 1'b1;
  logic        sclk_prev = 1'b0;
  logic        line_val;
  logic [1:0]  cur_slave;
  logic [23:0] cur_frame;
  logic [7:0]  cur_reply;
  logic [23:0] rx_bits;
  logic [23:0] exp_bits;
  int          bit_cnt;
  logic        cs_idle;
  logic [2:0]  csn_now;

  assign cs_idle = spi_csn_clk & spi_csn_dac & spi_csn_adc;
  assign csn_now = {spi_csn_adc, spi_csn_dac, spi_csn_clk};

  always @(posedge clk) begin
    #2;
    line_val = sdio_oe ? sdio_out : sdio_in;
    if (cs_prev && !cs_idle) begin
      assert (pending_q.size() > 0) else report_error("chip select dropped with no command");
      {cur_slave, cur_frame, cur_reply} = pending_q.pop_front();
      bit_cnt = 0;
      rx_bits = '0;
    end
    if (!cs_idle && spi_clk && !sclk_prev) begin
      assert (csn_now == ~(3'b001 << cur_slave))
        else report_error($sformatf("chip selects %03b for slave %0d", csn_now, cur_slave));
      if (cur_frame[23]) begin
        assert (sdio_oe == (bit_cnt < 16) && spi_dir == (bit_cnt < 16))
          else report_error($sformatf("sdio_oe %0b spi_dir %0b at read bit %0d",
                                      sdio_oe, spi_dir, bit_cnt));
      end else begin
        assert (spi_dir && sdio_oe) else report_error("line released during a write frame");
      end
      rx_bits = {rx_bits[22:0], line_val};
      bit_cnt++;
    end
    // reply bits change after the falling edge
    if (!cs_idle && !spi_clk && sclk_prev && cur_frame[23] && bit_cnt >= 16 && bit_cnt < 24) begin
      sdio_in = cur_reply[23 - bit_cnt];
    end
    if (!cs_prev && cs_idle) begin
      exp_bits = cur_frame[23] ? {cur_frame[23:8], cur_reply} : cur_frame;
      assert (bit_cnt == 24) else report_error($sformatf("frame of %0d bits", bit_cnt));
      assert (rx_bits == exp_bits)
        else report_error($sformatf("frame %06h, expected %06h", rx_bits, exp_bits));
      frames_done++;
      sdio_in = 1'b0;
    end
    cs_prev   = cs_idle;
    sclk_prev = spi_clk;
  end

  // ****************************************
  // watchdog and main sequence
  // ****************************************

  initial begin
    wait (num_cases > 0);
    repeat (num_cases * 200) @(posedge clk);
    $display("timeout, the cases did not finish within %0d clock cycles", num_cases * 200);
    $display(">>> FAIL");
    $fatal(1, "watchdog expired");
  end

  initial begin
    int unsigned gap;
    logic [31:0] rd;
    logic        err;
    int          waits;
    logic [7:0]  a;
    logic [31:0] v;
    logic [31:0] e;
    void'($urandom(32'h808d));
    rst_n       = 1'b0;
    paddr       = '0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    pwdata      = '0;
    gpio_bd_in  = '0;
    trig        = 1'b0;
    adc_fda     = 1'b0;
    adc_fdb     = 1'b0;
    dac_irq     = 1'b0;
    clkd_status = '0;
    load_cases();
    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;

    assert (spi_csn_clk && spi_csn_dac && spi_csn_adc) else report_error("select low after reset");
    assert (!spi_clk && !sdio_oe && !spi_dir) else report_error("SPI pins active after reset");
    assert (gpio_bd == 16'd0 && !sysref && !adc_pd && !dac_txen)
      else report_error("control outputs not 0 after reset");

    for (int i = 0; i < num_cases; i++) begin
      gap = $urandom % 4;
      repeat (gap) @(posedge clk);
      a = case_addr[i];
      v = case_val[i];
      e = case_exp[i];
      if (case_op[i] == "W") begin
        bus_access(1'b1, a, v, rd, err, waits);
        assert (err == e[0]) else report_error($sformatf("write %02h pslverr %0b", a, err));
        if (a == daq3_pkg::REG_BD_OUT) begin
          assert (gpio_bd == v[15:0]) else report_error($sformatf("gpio_bd_o %04h", gpio_bd));
        end
        if (a == daq3_pkg::REG_CTRL) begin
          assert ({dac_txen, adc_pd, sysref} == v[2:0])
            else report_error($sformatf("ctrl pins %03b", {dac_txen, adc_pd, sysref}));
        end
      end else if (case_op[i] == "R" || case_op[i] == "PIN") begin
        if (case_op[i] == "PIN") begin
          set_pins(v[16:0]);
          repeat (daq3_pkg::SYNC_STAGES + 2) @(posedge clk);
        end
        bus_access(1'b0, a, 32'd0, rd, err, waits);
        assert (err == !is_mapped(a))
          else report_error($sformatf("read %02h pslverr %0b", a, err));
        assert (rd == e)
          else report_error($sformatf("read %02h gave %08h, expected %08h", a, rd, e));
      end else if (case_op[i] == "SPI") begin
        run_spi(a, v[23:0], e[7:0]);
      end else begin
        report_error($sformatf("unknown opcode %s in case %0d", case_op[i], i));
      end
    end

    repeat (4) @(posedge clk);
    assert (pending_q.size() == 0) else report_error("SPI commands never reached the bus");
    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire
